// ==== hw/video_timing_pkg.sv ====
// Scan geometry defaults and scan position types, used by the timing and display blocks
package video_timing_pkg;

  //////////////////////////////
  // Default 128x96 geometry
  //////////////////////////////
  localparam int H_ACTIVE = 128;
  localparam int H_FRONT  = 8;
  localparam int H_SYNC   = 16;
  localparam int H_BACK   = 8;   // 160 counts per line

  localparam int V_ACTIVE = 96;
  localparam int V_FRONT  = 2;
  localparam int V_SYNC   = 2;
  localparam int V_BACK   = 4;   // 104 lines per frame

  //////////////////////////////
  // Scan types
  //////////////////////////////
  typedef logic [6:0] column_t;   // Active column 0..127
  typedef logic [6:0] row_t;      // Active row 0..95
  typedef logic [7:0] h_count_t;  // Whole line
  typedef logic [6:0] v_count_t;  // Whole frame

  // Current scan position, as seen by memory and output stage
  typedef struct packed {
    column_t column;
    row_t    row;
    logic    active;   // Inside the visible region
    logic    hsync_n;
    logic    vsync_n;
  } scan_pos_t;

endpackage

// ==== hw/pixel_pkg.sv ====
// Colour and frame memory write types shared by the host port and the frame buffer
package pixel_pkg;

  // One bit per gun
  typedef struct packed {
    logic red;
    logic green;
    logic blue;
  } rgb_t;

  typedef logic [13:0] frame_addr_t;   // {row, column}

  localparam int FRAME_DEPTH = 12288;  // 96 rows of 128

  // Host pixel write, strobe only, always accepted
  typedef struct packed {
    logic                      strobe;
    video_timing_pkg::row_t    row;
    video_timing_pkg::column_t column;
    rgb_t                      colour;
  } pixel_write_t;

  // Write into frame memory
  typedef struct packed {
    logic        enable;
    frame_addr_t addr;
    rgb_t        colour;
  } mem_write_t;

endpackage

// ==== hw/line_timing.sv ====
// Horizontal scan counter; drives the active column, hsync and a one-cycle line-end strobe
`timescale 1ns/1ps

module line_timing #(
  parameter int H_ACTIVE = video_timing_pkg::H_ACTIVE,
  parameter int H_FRONT  = video_timing_pkg::H_FRONT,
  parameter int H_SYNC   = video_timing_pkg::H_SYNC,
  parameter int H_BACK   = video_timing_pkg::H_BACK
) (
  input  logic                      clk,
  input  logic                      reset_synchronous,
  output video_timing_pkg::column_t column,
  output logic                      h_active,
  output logic                      hsync_n,
  output logic                      line_end
);

  localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

  // Porch boundaries in counter width
  localparam video_timing_pkg::h_count_t ACTIVE_END = video_timing_pkg::h_count_t'(H_ACTIVE);
  localparam video_timing_pkg::h_count_t SYNC_START =
    video_timing_pkg::h_count_t'(H_ACTIVE + H_FRONT);
  localparam video_timing_pkg::h_count_t SYNC_END   =
    video_timing_pkg::h_count_t'(H_ACTIVE + H_FRONT + H_SYNC);
  localparam video_timing_pkg::h_count_t LAST_COUNT = video_timing_pkg::h_count_t'(H_TOTAL - 1);

  video_timing_pkg::h_count_t h_count;

  always_ff @(posedge clk)
  begin
    if (reset_synchronous)
    begin
      h_count <= '0;
    end
    else if (line_end)
    begin
      h_count <= '0;  // Wrap at end of line
    end
    else
    begin
      h_count <= h_count + video_timing_pkg::h_count_t'(1);
    end
  end

  assign line_end = (h_count == LAST_COUNT);
  assign h_active = (h_count < ACTIVE_END);
  assign hsync_n  = !((h_count >= SYNC_START) && (h_count < SYNC_END));  // Active low
  assign column   = video_timing_pkg::column_t'(h_count);  // Meaningful only when active

  // Single-cycle strobe, repeating every line
  assert property (@(posedge clk) disable iff (reset_synchronous)
    line_end |=> !line_end ##(H_TOTAL - 1) line_end);

  // Sync pulse sits inside horizontal blanking
  assert property (@(posedge clk) disable iff (reset_synchronous)
    !hsync_n |-> !h_active);

endmodule

// ==== hw/frame_timing.sv ====
// Vertical line counter stepped by the line-end strobe; drives row, vsync and the active flag
`timescale 1ns/1ps

module frame_timing #(
  parameter int V_ACTIVE = video_timing_pkg::V_ACTIVE,
  parameter int V_FRONT  = video_timing_pkg::V_FRONT,
  parameter int V_SYNC   = video_timing_pkg::V_SYNC,
  parameter int V_BACK   = video_timing_pkg::V_BACK
) (
  input  logic                   clk,
  input  logic                   reset_synchronous,
  input  logic                   line_end,
  output video_timing_pkg::row_t row,
  output logic                   v_active,
  output logic                   vsync_n
);

  localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

  localparam video_timing_pkg::v_count_t ACTIVE_END = video_timing_pkg::v_count_t'(V_ACTIVE);
  localparam video_timing_pkg::v_count_t SYNC_START =
    video_timing_pkg::v_count_t'(V_ACTIVE + V_FRONT);
  localparam video_timing_pkg::v_count_t SYNC_END   =
    video_timing_pkg::v_count_t'(V_ACTIVE + V_FRONT + V_SYNC);
  localparam video_timing_pkg::v_count_t LAST_LINE  = video_timing_pkg::v_count_t'(V_TOTAL - 1);

  video_timing_pkg::v_count_t v_count;

  // Steps once per line, on the clock
  always_ff @(posedge clk)
  begin
    if (reset_synchronous)
    begin
      v_count <= '0;
    end
    else if (line_end)
    begin
      if (v_count == LAST_LINE)
      begin
        v_count <= '0;  // New frame
      end
      else
      begin
        v_count <= v_count + video_timing_pkg::v_count_t'(1);
      end
    end
  end

  assign v_active = (v_count < ACTIVE_END);
  assign vsync_n  = !((v_count >= SYNC_START) && (v_count < SYNC_END));
  assign row      = video_timing_pkg::row_t'(v_count);

  // Counter stays inside the frame for any porch setting
  assert property (@(posedge clk) disable iff (reset_synchronous)
    v_count <= LAST_LINE);

endmodule

// ==== hw/pixel_write_port.sv ====
// Host pixel write port; drops rows outside the frame and registers writes toward frame memory
`timescale 1ns/1ps

module pixel_write_port (
  input  logic                    clk,
  input  logic                    reset_synchronous,
  input  pixel_pkg::pixel_write_t host_write,
  output pixel_pkg::mem_write_t   mem_write
);

  localparam pixel_pkg::frame_addr_t FRAME_LIMIT =
    pixel_pkg::frame_addr_t'(pixel_pkg::FRAME_DEPTH);
  localparam int FRAME_ROWS =
    pixel_pkg::FRAME_DEPTH / (2 ** $bits(video_timing_pkg::column_t));

  pixel_pkg::frame_addr_t addr;
  logic                   in_frame;

  assign addr     = {host_write.row, host_write.column};  // Row above column
  assign in_frame = (host_write.row < FRAME_ROWS);        // Row below 96

  //////////////////////////////
  // Write register
  //////////////////////////////
  always_ff @(posedge clk)
  begin
    mem_write.addr   <= addr;
    mem_write.colour <= host_write.colour;
    if (reset_synchronous)
    begin
      mem_write.enable <= 1'b0;
    end
    else
    begin
      mem_write.enable <= host_write.strobe && in_frame;
    end
  end

  // Memory never sees an address past the frame
  assert property (@(posedge clk) disable iff (reset_synchronous)
    mem_write.enable |-> (mem_write.addr < FRAME_LIMIT));

endmodule

// ==== hw/frame_buffer.sv ====
// Frame memory of 3-bit colour; one host write port and one registered scan read port
`timescale 1ns/1ps

module frame_buffer (
  input  logic                       clk,
  input  pixel_pkg::mem_write_t      mem_write,
  input  video_timing_pkg::scan_pos_t scan,
  output pixel_pkg::rgb_t            pixel
);

  // Starts black
  pixel_pkg::rgb_t mem [pixel_pkg::FRAME_DEPTH] = '{default: '0};

  pixel_pkg::frame_addr_t read_addr;

  // Formed during blanking too, the data is dropped downstream
  assign read_addr = {scan.row, scan.column};

  //////////////////////////////
  // Write and read ports
  //////////////////////////////
  always_ff @(posedge clk)
  begin
    if (mem_write.enable)
    begin
      mem[mem_write.addr] <= mem_write.colour;
    end
  end

  // Read before write on a shared address
  always_ff @(posedge clk)
  begin
    pixel <= mem[read_addr];  // One cycle latency
  end

endmodule

// ==== hw/video_output.sv ====
// Output stage; aligns syncs with memory data, blanks colour and registers the VGA pins
`timescale 1ns/1ps

module video_output (
  input  logic                        clk,
  input  logic                        reset_synchronous,
  input  video_timing_pkg::scan_pos_t scan,
  input  pixel_pkg::rgb_t             pixel,
  output logic                        vga_red,
  output logic                        vga_green,
  output logic                        vga_blue,
  output logic                        vga_hsync,
  output logic                        vga_vsync
);

  logic            active_d;
  logic            hsync_d;
  logic            vsync_d;
  pixel_pkg::rgb_t colour;

  // Match the memory read latency
  always_ff @(posedge clk)
  begin
    if (reset_synchronous)
    begin
      active_d <= 1'b0;
      hsync_d  <= 1'b1;  // Inactive
      vsync_d  <= 1'b1;
    end
    else
    begin
      active_d <= scan.active;
      hsync_d  <= scan.hsync_n;
      vsync_d  <= scan.vsync_n;
    end
  end

  assign colour = active_d ? pixel : '0;  // Black in porches and sync

  // Pin registers
  always_ff @(posedge clk)
  begin
    if (reset_synchronous)
    begin
      vga_red   <= 1'b0;
      vga_green <= 1'b0;
      vga_blue  <= 1'b0;
      vga_hsync <= 1'b1;
      vga_vsync <= 1'b1;
    end
    else
    begin
      vga_red   <= colour.red;
      vga_green <= colour.green;
      vga_blue  <= colour.blue;
      vga_hsync <= hsync_d;
      vga_vsync <= vsync_d;
    end
  end

endmodule

// ==== hw/vga_top.sv ====
// Top level of the 128x96 VGA generator; sets the scan geometry and wires the blocks together
`timescale 1ns/1ps

module vga_top #(
  parameter int H_ACTIVE = video_timing_pkg::H_ACTIVE,
  parameter int H_FRONT  = video_timing_pkg::H_FRONT,
  parameter int H_SYNC   = video_timing_pkg::H_SYNC,
  parameter int H_BACK   = video_timing_pkg::H_BACK,
  parameter int V_ACTIVE = video_timing_pkg::V_ACTIVE,
  parameter int V_FRONT  = video_timing_pkg::V_FRONT,
  parameter int V_SYNC   = video_timing_pkg::V_SYNC,
  parameter int V_BACK   = video_timing_pkg::V_BACK
) (
  input  logic                    clk,
  input  logic                    reset_synchronous,
  input  pixel_pkg::pixel_write_t host_write,
  output logic                    vga_red,
  output logic                    vga_green,
  output logic                    vga_blue,
  output logic                    vga_hsync,
  output logic                    vga_vsync
);

  video_timing_pkg::column_t   column;
  video_timing_pkg::row_t      row;
  logic                        h_active;
  logic                        v_active;
  logic                        hsync_n;
  logic                        vsync_n;
  logic                        line_end;
  video_timing_pkg::scan_pos_t scan;
  pixel_pkg::mem_write_t       mem_write;
  pixel_pkg::rgb_t             pixel;

  //////////////////////////////
  // Scan path
  //////////////////////////////
  line_timing #(.H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK))
    u_line_timing (.clk, .reset_synchronous, .column, .h_active, .hsync_n, .line_end);

  frame_timing #(.V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK))
    u_frame_timing (.clk, .reset_synchronous, .line_end, .row, .v_active, .vsync_n);

  assign scan = '{column: column, row: row, active: h_active && v_active,
                  hsync_n: hsync_n, vsync_n: vsync_n};

  //////////////////////////////
  // Memory and pins
  //////////////////////////////
  pixel_write_port u_pixel_write_port (.clk, .reset_synchronous, .host_write, .mem_write);

  frame_buffer u_frame_buffer (.clk, .mem_write, .scan, .pixel);

  video_output u_video_output (
    .clk, .reset_synchronous, .scan, .pixel,
    .vga_red, .vga_green, .vga_blue, .vga_hsync, .vga_vsync
  );

endmodule

// ==== sim/tb_checks.svh ====
// Testbench helpers for the VGA generator, with the LCG, picture model, reference pins and compares
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

//////////////////////////////
// Scan geometry
//////////////////////////////
localparam int H_ACTIVE     = video_timing_pkg::H_ACTIVE;
localparam int H_SYNC_START = H_ACTIVE + video_timing_pkg::H_FRONT;
localparam int H_SYNC_END   = H_SYNC_START + video_timing_pkg::H_SYNC;
localparam int H_TOTAL      = H_SYNC_END + video_timing_pkg::H_BACK;   // 160
localparam int V_ACTIVE     = video_timing_pkg::V_ACTIVE;
localparam int V_SYNC_START = V_ACTIVE + video_timing_pkg::V_FRONT;
localparam int V_SYNC_END   = V_SYNC_START + video_timing_pkg::V_SYNC;
localparam int V_TOTAL      = V_SYNC_END + video_timing_pkg::V_BACK;   // 104
localparam int TIMEOUT_CYCLES = 4 * V_TOTAL * H_TOTAL + 200;

// Pin values as the monitor sees them
typedef struct packed {
  pixel_pkg::rgb_t colour;
  logic            hsync;
  logic            vsync;
} pins_t;

// What frame memory should hold
pixel_pkg::rgb_t picture [V_ACTIVE][H_ACTIVE] = '{default: '0};

function automatic int unsigned lcg_next(input int unsigned state);
  return state * 32'd1664525 + 32'd1013904223;
endfunction

task automatic model_write(input int row, input int column, input pixel_pkg::rgb_t colour);
  if (row < V_ACTIVE)
  begin
    picture[row][column] = colour;  // Rows past the frame never land
  end
endtask

// Expected pins for a scan position
function automatic pins_t expected_pins(input int h, input int v);
  pins_t pins;
  pins.colour = '0;
  if ((h < H_ACTIVE) && (v < V_ACTIVE))
  begin
    pins.colour = picture[v][h];
  end
  pins.hsync = !((h >= H_SYNC_START) && (h < H_SYNC_END));
  pins.vsync = !((v >= V_SYNC_START) && (v < V_SYNC_END));
  return pins;
endfunction

task automatic check_rgb(input pixel_pkg::rgb_t got, input pixel_pkg::rgb_t expected,
                         input string what, inout int errors);
  if (got !== expected)
  begin
    $display("CHECK FAILED time %0t: %s colour %b, expected %b", $time, what, got, expected);
    errors++;
  end
endtask

task automatic check_sync(input logic got, input logic expected, input string what,
                          inout int errors);
  if (got !== expected)
  begin
    $display("CHECK FAILED time %0t: %s is %b, expected %b", $time, what, got, expected);
    errors++;
  end
endtask

`endif

// ==== sim/tb_vga_top.sv ====
// Testbench for the VGA generator; writes a picture through the host port and checks every pin
`timescale 1ns/1ps

module tb_vga_top;

  logic                    clk;
  logic                    reset_synchronous;
  pixel_pkg::pixel_write_t host_write;
  logic                    vga_red;
  logic                    vga_green;
  logic                    vga_blue;
  logic                    vga_hsync;
  logic                    vga_vsync;

  int   cycle = 0;  // Rising edges since reset release
  int   reset_errors = 0;
  int   hsync_errors = 0;
  int   vsync_errors = 0;
  int   pixel_errors = 0;
  int   range_errors = 0;
  int   blank_errors = 0;
  int   range_writes = 0;
  int   failed_tests = 0;
  logic compare_done = 1'b0;

  `include "tb_checks.svh"

  logic range_column [H_ACTIVE] = '{default: 1'b0};  // Columns hit by dropped writes

  vga_top uut (
    .clk(clk), .reset_synchronous(reset_synchronous), .host_write(host_write),
    .vga_red(vga_red), .vga_green(vga_green), .vga_blue(vga_blue),
    .vga_hsync(vga_hsync), .vga_vsync(vga_vsync)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk)
  begin
    if (!reset_synchronous)
    begin
      cycle <= cycle + 1;
    end
    if (cycle >= TIMEOUT_CYCLES)
    begin
      $display("Timeout after %0d cycles, the pin checks never completed", cycle);
      $display("Done: errors found");
      $finish;
    end
  end

  task automatic issue_write(input int row, input int column, input pixel_pkg::rgb_t colour);
    host_write.strobe = 1'b1;
    host_write.row    = video_timing_pkg::row_t'(row);
    host_write.column = video_timing_pkg::column_t'(column);
    host_write.colour = colour;
    model_write(row, column, colour);
    if (row >= V_ACTIVE)
    begin
      range_writes++;
      range_column[column] = 1'b1;
    end
    @(posedge clk);
    #1;
  endtask

  task automatic report_test(input string name, input int errors);
    if (errors == 0)
    begin
      $display("Test %s passed", name);
    end
    else
    begin
      $display("Test %s failed with %0d errors", name, errors);
      failed_tests++;
    end
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////
  initial
  begin : stimulus
    int unsigned state;
    int          total;
    state = 26867;
    host_write = '0;
    reset_synchronous = 1'b1;
    repeat (5) @(posedge clk);
    #1;
    reset_synchronous = 1'b0;
    while (cycle < V_ACTIVE * H_TOTAL)  // Wait for vertical blanking of frame 0
    begin
      @(posedge clk);
      #1;
    end
    for (int i = 0; i < 40; i++)
    begin
      state = lcg_next(state);
      issue_write(int'(state[30:24]), int'(state[22:16]), pixel_pkg::rgb_t'(state[14:12]));
    end
    // White frame edges
    for (int r = 0; r < V_ACTIVE; r++)
    begin
      issue_write(r, 0, 3'b111);
      issue_write(r, H_ACTIVE - 1, 3'b111);
    end
    for (int r = V_ACTIVE; r < V_ACTIVE + 8; r++)
    begin
      issue_write(r, r - V_ACTIVE + 40, 3'b111);
    end
    host_write = '0;
    wait (compare_done);
    total = reset_errors + hsync_errors + vsync_errors + pixel_errors + range_errors
          + blank_errors;
    $display("Summary: %0d of 6 tests failed, %0d check errors", failed_tests, total);
    if ((failed_tests == 0) && (total == 0))
    begin
      $display("Done: no errors");
    end
    else
    begin
      $display("Done: errors found");
    end
    $finish;
  end

  //////////////////////////////
  // Pin monitor
  //////////////////////////////
  initial
  begin : compare
    int    h;
    int    v;
    int    frame;
    pins_t got;
    pins_t exp;
    logic  hsync_prev;
    logic  vsync_prev;
    logic  hsync_fell;
    logic  vsync_fell;
    h = 0;
    v = 0;
    frame = 0;
    hsync_prev = 1'b1;
    vsync_prev = 1'b1;
    hsync_fell = 1'b0;
    vsync_fell = 1'b0;
    @(negedge clk);
    while (cycle < 2)  // Reset and the two cycles of pipeline after it
    begin
      got = {vga_red, vga_green, vga_blue, vga_hsync, vga_vsync};
      check_rgb(got.colour, '0, "reset", reset_errors);
      check_sync(got.hsync, 1'b1, "reset hsync", reset_errors);
      check_sync(got.vsync, 1'b1, "reset vsync", reset_errors);
      @(negedge clk);
    end
    report_test("1 reset", reset_errors);
    while (frame < 2)
    begin
      got = {vga_red, vga_green, vga_blue, vga_hsync, vga_vsync};
      exp = expected_pins(h, v);
      if ((h < H_ACTIVE) && (v < V_ACTIVE))
      begin
        if (range_column[h] && (got.colour !== exp.colour))
        begin
          range_errors++;
        end
        check_rgb(got.colour, exp.colour, "active pixel", pixel_errors);
      end
      else
      begin
        check_rgb(got.colour, exp.colour, "blanking", blank_errors);
      end
      check_sync(got.hsync, exp.hsync, "hsync", hsync_errors);
      check_sync(got.vsync, exp.vsync, "vsync", vsync_errors);
      if (hsync_prev && !got.hsync && !hsync_fell)
      begin
        hsync_fell = 1'b1;
        if (cycle != H_SYNC_START + 2)
        begin
          $display("CHECK FAILED time %0t: first hsync fall at cycle %0d", $time, cycle);
          hsync_errors++;
        end
      end
      if (vsync_prev && !got.vsync && !vsync_fell)
      begin
        vsync_fell = 1'b1;
        if ((v != V_SYNC_START) || (h != 0))
        begin
          $display("CHECK FAILED time %0t: first vsync fall at line %0d", $time, v);
          vsync_errors++;
        end
      end
      hsync_prev = got.hsync;
      vsync_prev = got.vsync;
      h++;
      if (h == H_TOTAL)
      begin
        h = 0;
        v++;
        if (v == V_TOTAL)
        begin
          v = 0;
          frame++;
        end
      end
      @(negedge clk);
    end
    if (!hsync_fell || !vsync_fell)
    begin
      $display("A sync pin never went low during the first two frames");
      hsync_errors++;
    end
    if (range_writes == 0)
    begin
      $display("No out-of-range write was issued, so test 5 checked nothing");
      range_errors++;
    end
    report_test("2 horizontal timing", hsync_errors);
    report_test("3 vertical timing", vsync_errors);
    report_test("4 writes and black memory", pixel_errors);
    report_test("5 out-of-range writes", range_errors);
    report_test("6 blanking", blank_errors);
    compare_done = 1'b1;
  end

endmodule

// ==== files.f ====
+incdir+sim
hw/video_timing_pkg.sv
hw/pixel_pkg.sv
hw/line_timing.sv
hw/frame_timing.sv
hw/pixel_write_port.sv
hw/frame_buffer.sv
hw/video_output.sv
hw/vga_top.sv
sim/tb_vga_top.sv

// ==== Makefile ====
# Verilator lint and simulation of the VGA generator

TOP = tb_vga_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f files.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log
